// ==== hw/feat_pkg.sv ====
package feat_pkg;

	// Activation channel, signed
	localparam int FEAT_W = 8;

	// Accumulator for bias plus the sum of products
	localparam int ACC_W = 24;

	// Dequantised head channel, signed
	localparam int OUT_W = 16;

	// Channels per input pixel
	localparam int PIX_CH = 3;

	// ReLU output clamps to the positive range of a signed byte
	localparam int RELU_MAX = 127;

	// Saturation limits of a head channel
	localparam int OUT_MAX = 32767;
	localparam int OUT_MIN = -32768;

	typedef enum logic {
		OUT_RELU    = 1'b0, // Shift then clamp 0..127
		OUT_DEQUANT = 1'b1  // Scale, shift, saturate
	} out_mode_e;

endpackage

// ==== hw/wload_pkg.sv ====
package wload_pkg;

	localparam int WADDR_W = 16;

	typedef struct packed {
		logic [7:0]        rsvd;
		logic signed [7:0] weight;
	} kern_word_t;

	typedef struct packed {
		logic [7:0] scale; // Unsigned multiplier
		logic [3:0] shift;
		logic [3:0] rsvd;
	} quant_word_t;

	// Meaning of the data word depends on where the address lands
	typedef union packed {
		logic signed [15:0] bias;
		kern_word_t         kern;
		quant_word_t        quant;
	} wt_word_u;

	typedef struct packed {
		logic               en;
		logic [WADDR_W-1:0] addr;
		wt_word_u           data;
	} wt_wr_t;

	// Kernels, then biases, then one quant word
	function automatic int win_size(int in_ch, int out_ch);
		return out_ch * in_ch + out_ch + 1;
	endfunction

endpackage

// ==== hw/weight_bank.sv ====
module weight_bank #(
	parameter int IN_CH     = 8,
	parameter int OUT_CH    = 8,
	parameter int KERN_BASE = 0
) (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  wload_pkg::wt_wr_t i_wt_wr,
	output logic signed [7:0]  o_kern [OUT_CH*IN_CH],
	output logic signed [15:0] o_bias [OUT_CH],
	output logic [7:0]         o_scale,
	output logic [3:0]         o_shift
);

	import wload_pkg::*;

	localparam int N_KERN   = OUT_CH * IN_CH;
	localparam int WIN_SIZE = win_size(IN_CH, OUT_CH);
	localparam int Q_OFFS   = N_KERN + OUT_CH; // Quant word sits last

	logic [WADDR_W-1:0] offs;
	logic               in_win;
	logic               is_kern;
	logic               is_bias;
	logic               is_quant;

	assign offs   = i_wt_wr.addr - WADDR_W'(KERN_BASE);
	assign in_win = i_wt_wr.en && (i_wt_wr.addr >= WADDR_W'(KERN_BASE)) &&
		(offs < WADDR_W'(WIN_SIZE));

	assign is_kern  = in_win && (offs < WADDR_W'(N_KERN));
	assign is_bias  = in_win && !is_kern && (offs < WADDR_W'(Q_OFFS));
	assign is_quant = in_win && (offs == WADDR_W'(Q_OFFS));

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int k = 0; k < N_KERN; k++) begin
				o_kern[k] <= '0;
			end
			for (int b = 0; b < OUT_CH; b++) begin
				o_bias[b] <= '0;
			end
			o_scale <= '0;
			o_shift <= '0;
		end else begin
			for (int k = 0; k < N_KERN; k++) begin
				if (is_kern && offs == WADDR_W'(k)) begin
					o_kern[k] <= i_wt_wr.data.kern.weight;
				end
			end
			for (int b = 0; b < OUT_CH; b++) begin
				if (is_bias && offs == WADDR_W'(N_KERN + b)) begin
					o_bias[b] <= i_wt_wr.data.bias;
				end
			end
			if (is_quant) begin
				o_scale <= i_wt_wr.data.quant.scale;
				o_shift <= i_wt_wr.data.quant.shift;
			end
		end
	end

endmodule

// ==== hw/pw_conv_layer.sv ====
module pw_conv_layer #(
	parameter int                  IN_CH     = 8,
	parameter int                  OUT_CH    = 8,
	parameter int                  KERN_BASE = 0,
	parameter feat_pkg::out_mode_e OUT_MODE  = feat_pkg::OUT_RELU,
	localparam int O_W = (OUT_MODE == feat_pkg::OUT_RELU) ? feat_pkg::FEAT_W : feat_pkg::OUT_W
) (
	input  logic                                i_clk,
	input  logic                                i_arst_n,
	input  logic [IN_CH*feat_pkg::FEAT_W-1:0]   i_data,
	input  logic                                i_valid,
	output logic                                o_rd_en,
	input  logic                                i_almost_full,
	output logic [OUT_CH*O_W-1:0]               o_data,
	output logic                                o_valid,
	input  wload_pkg::wt_wr_t                   i_wt_wr
);

	import feat_pkg::*;

	logic signed [FEAT_W-1:0] kern [OUT_CH*IN_CH];
	logic signed [15:0]       bias [OUT_CH];
	logic [7:0]               q_scale;
	logic [3:0]               q_shift;
	logic signed [ACC_W-1:0]  acc [OUT_CH];
	logic [OUT_CH*O_W-1:0]    res;

	weight_bank #(
		.IN_CH     (IN_CH),
		.OUT_CH    (OUT_CH),
		.KERN_BASE (KERN_BASE)
	) u_weight_bank (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_wt_wr  (i_wt_wr),
		.o_kern   (kern),
		.o_bias   (bias),
		.o_scale  (q_scale),
		.o_shift  (q_shift)
	);

	assign o_rd_en = i_valid && !i_almost_full; // Pop head word

	always_comb begin
		for (int o = 0; o < OUT_CH; o++) begin
			acc[o] = ACC_W'(bias[o]);
			for (int i = 0; i < IN_CH; i++) begin
				acc[o] += kern[o*IN_CH + i] * $signed(i_data[i*FEAT_W +: FEAT_W]);
			end
		end
	end

	if (OUT_MODE == OUT_RELU) begin : g_relu
		always_comb begin
			logic signed [ACC_W-1:0] shd;
			for (int o = 0; o < OUT_CH; o++) begin
				shd = acc[o] >>> q_shift;
				if (shd < 0)
					res[o*O_W +: O_W] = '0;
				else if (shd > RELU_MAX)
					res[o*O_W +: O_W] = O_W'(RELU_MAX);
				else
					res[o*O_W +: O_W] = shd[O_W-1:0];
			end
		end
	end else begin : g_dequant
		always_comb begin
			logic signed [ACC_W+8:0] prod; // Room for the 9-bit signed scale
			logic signed [ACC_W+8:0] shd;
			for (int o = 0; o < OUT_CH; o++) begin
				prod = acc[o] * $signed({1'b0, q_scale});
				shd  = prod >>> q_shift;
				if (shd > OUT_MAX)
					res[o*O_W +: O_W] = O_W'(OUT_MAX);
				else if (shd < OUT_MIN)
					res[o*O_W +: O_W] = O_W'(OUT_MIN);
				else
					res[o*O_W +: O_W] = shd[O_W-1:0];
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_valid <= 1'b0;
		else
			o_valid <= o_rd_en;
	end

	always_ff @(posedge i_clk) begin
		if (o_rd_en)
			o_data <= res;
	end

	a_pop_data_known: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_rd_en |-> !$isunknown(i_data));

endmodule

// ==== hw/stream_fifo.sv ====
module stream_fifo #(
	parameter int WIDTH    = 64,
	parameter int DEPTH    = 16,
	parameter int AF_THRES = 4
) (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic [WIDTH-1:0] i_wr_data,
	input  logic             i_wr_en,
	input  logic             i_rd_en,
	output logic [WIDTH-1:0] o_rd_data,
	output logic             o_empty,
	output logic             o_almost_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign o_rd_data     = mem[rd_ptr]; // Fall-through head
	assign o_empty       = (count == '0);
	assign o_almost_full = (DEPTH - int'(count)) <= AF_THRES;

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			mem[wr_ptr] <= i_wr_data;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({i_wr_en, i_rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wr_en |-> count != CNT_W'(DEPTH));

	a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rd_en |-> !o_empty);

endmodule

// ==== hw/fork_fifo.sv ====
module fork_fifo #(
	parameter int WIDTH    = 64,
	parameter int DEPTH    = 16,
	parameter int AF_THRES = 4
) (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic [WIDTH-1:0] i_wr_data,
	input  logic             i_wr_en,
	input  logic             i_rd_en_a,
	input  logic             i_rd_en_b,
	output logic [WIDTH-1:0] o_rd_data_a,
	output logic [WIDTH-1:0] o_rd_data_b,
	output logic             o_empty_a,
	output logic             o_empty_b,
	output logic             o_almost_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr_a;
	logic [PTR_W-1:0] rd_ptr_b;
	logic [CNT_W-1:0] cnt_a; // Entries port a has not read yet
	logic [CNT_W-1:0] cnt_b;
	logic [CNT_W-1:0] occ;

	// Slower reader holds the entries
	assign occ = (cnt_a > cnt_b) ? cnt_a : cnt_b;

	assign o_rd_data_a   = mem[rd_ptr_a];
	assign o_rd_data_b   = mem[rd_ptr_b];
	assign o_empty_a     = (cnt_a == '0);
	assign o_empty_b     = (cnt_b == '0);
	assign o_almost_full = (DEPTH - int'(occ)) <= AF_THRES;

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			mem[wr_ptr] <= i_wr_data;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr   <= '0;
			rd_ptr_a <= '0;
			rd_ptr_b <= '0;
			cnt_a    <= '0;
			cnt_b    <= '0;
		end else begin
			if (i_wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_rd_en_a)
				rd_ptr_a <= (rd_ptr_a == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_a + 1'b1;
			if (i_rd_en_b)
				rd_ptr_b <= (rd_ptr_b == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_b + 1'b1;
			cnt_a <= cnt_a + CNT_W'(i_wr_en) - CNT_W'(i_rd_en_a);
			cnt_b <= cnt_b + CNT_W'(i_wr_en) - CNT_W'(i_rd_en_b);
		end
	end

	a_no_underflow_a: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rd_en_a |-> !o_empty_a);

	a_no_underflow_b: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_rd_en_b |-> !o_empty_b);

endmodule

// ==== hw/cnn_top.sv ====
module cnn_top (
	input  logic                                        i_clk,
	input  logic                                        i_arst_n,
	input  logic [feat_pkg::PIX_CH*feat_pkg::FEAT_W-1:0] i_pix,
	input  logic                                        i_pix_valid,
	output logic                                        o_pix_rd_en,
	input  wload_pkg::wt_wr_t                           i_wt_wr,
	output logic [4*feat_pkg::OUT_W-1:0]                o_cls_data,
	output logic [4*feat_pkg::OUT_W-1:0]                o_vert_data,
	output logic                                        o_cls_valid,
	output logic                                        o_vert_valid,
	input  logic                                        i_cls_almost_full,
	input  logic                                        i_vert_almost_full
);

	import feat_pkg::*;

	localparam int ENC_CH  = 8;
	localparam int HEAD_CH = 4;

	// Weight windows
	localparam int ENC0_BASE = 0;   // 24 kern, 8 bias, 1 quant
	localparam int ENC1_BASE = 64;  // 64 kern, 8 bias, 1 quant
	localparam int CLS_BASE  = 160;
	localparam int VERT_BASE = 208;

	localparam int FIFO_DEPTH = 16;
	localparam int AF_THRES   = 4;

	logic [ENC_CH*FEAT_W-1:0] enc_0_data;
	logic                     enc_0_valid;
	logic [ENC_CH*FEAT_W-1:0] fifo_enc_0_rd_data;
	logic                     fifo_enc_0_empty;
	logic                     fifo_enc_0_rd_en;
	logic                     fifo_enc_0_af;
	logic [ENC_CH*FEAT_W-1:0] enc_1_data;
	logic                     enc_1_valid;
	logic [ENC_CH*FEAT_W-1:0] fork_rd_data_a;
	logic [ENC_CH*FEAT_W-1:0] fork_rd_data_b;
	logic                     fork_empty_a;
	logic                     fork_empty_b;
	logic                     fork_rd_en_a;
	logic                     fork_rd_en_b;
	logic                     fork_af;

	pw_conv_layer #(
		.IN_CH     (PIX_CH),
		.OUT_CH    (ENC_CH),
		.KERN_BASE (ENC0_BASE),
		.OUT_MODE  (OUT_RELU)
	) u_enc_0 (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_data        (i_pix),
		.i_valid       (i_pix_valid),
		.o_rd_en       (o_pix_rd_en),
		.i_almost_full (fifo_enc_0_af),
		.o_data        (enc_0_data),
		.o_valid       (enc_0_valid),
		.i_wt_wr       (i_wt_wr)
	);

	stream_fifo #(
		.WIDTH    (ENC_CH * FEAT_W),
		.DEPTH    (FIFO_DEPTH),
		.AF_THRES (AF_THRES)
	) u_fifo_enc_0 (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_wr_data     (enc_0_data),
		.i_wr_en       (enc_0_valid),
		.i_rd_en       (fifo_enc_0_rd_en),
		.o_rd_data     (fifo_enc_0_rd_data),
		.o_empty       (fifo_enc_0_empty),
		.o_almost_full (fifo_enc_0_af)
	);

	pw_conv_layer #(
		.IN_CH     (ENC_CH),
		.OUT_CH    (ENC_CH),
		.KERN_BASE (ENC1_BASE),
		.OUT_MODE  (OUT_RELU)
	) u_enc_1 (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_data        (fifo_enc_0_rd_data),
		.i_valid       (!fifo_enc_0_empty),
		.o_rd_en       (fifo_enc_0_rd_en),
		.i_almost_full (fork_af),
		.o_data        (enc_1_data),
		.o_valid       (enc_1_valid),
		.i_wt_wr       (i_wt_wr)
	);

	fork_fifo #(
		.WIDTH    (ENC_CH * FEAT_W),
		.DEPTH    (FIFO_DEPTH),
		.AF_THRES (AF_THRES)
	) u_fifo_fork (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_wr_data     (enc_1_data),
		.i_wr_en       (enc_1_valid),
		.i_rd_en_a     (fork_rd_en_a),
		.i_rd_en_b     (fork_rd_en_b),
		.o_rd_data_a   (fork_rd_data_a),
		.o_rd_data_b   (fork_rd_data_b),
		.o_empty_a     (fork_empty_a),
		.o_empty_b     (fork_empty_b),
		.o_almost_full (fork_af)
	);

	// Port a feeds cls
	pw_conv_layer #(
		.IN_CH     (ENC_CH),
		.OUT_CH    (HEAD_CH),
		.KERN_BASE (CLS_BASE),
		.OUT_MODE  (OUT_DEQUANT)
	) u_cls (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_data        (fork_rd_data_a),
		.i_valid       (!fork_empty_a),
		.o_rd_en       (fork_rd_en_a),
		.i_almost_full (i_cls_almost_full),
		.o_data        (o_cls_data),
		.o_valid       (o_cls_valid),
		.i_wt_wr       (i_wt_wr)
	);

	pw_conv_layer #(
		.IN_CH     (ENC_CH),
		.OUT_CH    (HEAD_CH),
		.KERN_BASE (VERT_BASE),
		.OUT_MODE  (OUT_DEQUANT)
	) u_vert (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_data        (fork_rd_data_b),
		.i_valid       (!fork_empty_b),
		.o_rd_en       (fork_rd_en_b),
		.i_almost_full (i_vert_almost_full),
		.o_data        (o_vert_data),
		.o_valid       (o_vert_valid),
		.i_wt_wr       (i_wt_wr)
	);

endmodule

// ==== verif/cnn_model.svh ====
// Weight image indexed by bus address
logic [15:0] wmem [256];

localparam int ENC0_BASE = 0;
localparam int ENC1_BASE = 64;
localparam int CLS_BASE  = 160;
localparam int VERT_BASE = 208;

task automatic fill_window(input int base, input int in_ch, input int out_ch, input int shift);
	for (int k = 0; k < in_ch * out_ch; k++) begin
		wmem[base + k] = {8'($urandom), 8'($urandom_range(31)) - 8'd16}; // Junk in upper byte
	end
	for (int o = 0; o < out_ch; o++) begin
		wmem[base + in_ch * out_ch + o] = 16'($urandom_range(511)) - 16'd256;
	end
	wmem[base + out_ch * (in_ch + 1)] = {8'($urandom_range(255, 64)), 4'(shift), 4'($urandom)};
endtask

task automatic fill_weights();
	fill_window(ENC0_BASE, 3, 8, 5);
	fill_window(ENC1_BASE, 8, 8, 7);
	fill_window(CLS_BASE, 8, 4, 6);
	fill_window(VERT_BASE, 8, 4, 6);
endtask

task automatic write_window(input int base, input int in_ch, input int out_ch);
	for (int a = base; a <= base + out_ch * (in_ch + 1); a++) begin
		@(negedge clk);
		wt_wr.en   = 1'b1;
		wt_wr.addr = 16'(a);
		wt_wr.data = wmem[a];
	end
	@(negedge clk);
	wt_wr.en = 1'b0;
endtask

task automatic load_weights();
	write_window(ENC0_BASE, 3, 8);
	write_window(ENC1_BASE, 8, 8);
	write_window(CLS_BASE, 8, 4);
	write_window(VERT_BASE, 8, 4);
endtask

function automatic int layer_acc(input int base, input int in_ch, input int out_ch,
		input int o, input int x [8]);
	int acc;
	acc = int'($signed(wmem[base + out_ch * in_ch + o]));
	for (int i = 0; i < in_ch; i++) begin
		acc += int'($signed(wmem[base + o * in_ch + i][7:0])) * x[i];
	end
	return acc;
endfunction

function automatic void relu_layer(input int base, input int in_ch, input int x [8],
		output int y [8]);
	int sh;
	int v;
	sh = int'(wmem[base + 8 * (in_ch + 1)][7:4]);
	for (int o = 0; o < 8; o++) begin
		v = layer_acc(base, in_ch, 8, o, x) >>> sh;
		y[o] = (v < 0) ? 0 : ((v > 127) ? 127 : v);
	end
endfunction

// Full path for one pixel through both encoders into one head
function automatic logic [63:0] head_ref(input logic [23:0] p, input int base);
	int x [8];
	int h0 [8];
	int h1 [8];
	int sc;
	int sh;
	int v;
	logic [63:0] r;
	x = '{default: 0};
	for (int i = 0; i < 3; i++) begin
		x[i] = int'($signed(p[i*8 +: 8]));
	end
	relu_layer(ENC0_BASE, 3, x, h0);
	relu_layer(ENC1_BASE, 8, h0, h1);
	sc = int'(wmem[base + 36][15:8]);
	sh = int'(wmem[base + 36][7:4]);
	for (int o = 0; o < 4; o++) begin
		v = (layer_acc(base, 8, 4, o, h1) * sc) >>> sh;
		v = (v > 32767) ? 32767 : ((v < -32768) ? -32768 : v);
		r[o*16 +: 16] = 16'(v);
	end
	return r;
endfunction

// ==== verif/tb_cnn_top.sv ====
module tb_cnn_top;

	import wload_pkg::*;

	localparam int N_STREAM    = 200;
	localparam int N_HOLD      = 40;
	localparam int N_PIX       = 2 + N_STREAM + N_HOLD;
	localparam int CYCLE_LIMIT = 40 * N_PIX + 1000;

	logic        clk;
	logic        arst_n;
	logic [23:0] pix;
	logic        pix_valid;
	logic        pix_rd_en;
	wt_wr_t      wt_wr;
	logic [63:0] cls_data;
	logic [63:0] vert_data;
	logic        cls_valid;
	logic        vert_valid;
	logic        cls_af;
	logic        vert_af;

	logic [23:0] pix_q [$];
	logic [63:0] cls_q [$];
	logic [63:0] vert_q [$];
	logic [63:0] cls_exp;
	logic [63:0] vert_exp;
	logic        cls_have;
	logic        vert_have;
	logic        pix_taken;
	logic        cls_shown; // Result checked at the coming edge
	logic        vert_shown;
	logic        busy;
	int          cls_seen;
	int          vert_seen;
	int          val_errs;
	int          other_errs;
	int          c0;
	int          v0;

	`include "cnn_model.svh"

	cnn_top i_cnn_top (
		.i_clk              (clk),
		.i_arst_n           (arst_n),
		.i_pix              (pix),
		.i_pix_valid        (pix_valid),
		.o_pix_rd_en        (pix_rd_en),
		.i_wt_wr            (wt_wr),
		.o_cls_data         (cls_data),
		.o_vert_data        (vert_data),
		.o_cls_valid        (cls_valid),
		.o_vert_valid       (vert_valid),
		.i_cls_almost_full  (cls_af),
		.i_vert_almost_full (vert_af)
	);

	always #10 clk = ~clk;

	function automatic void show_queue_heads();
		pix_valid = (pix_q.size() > 0);
		pix       = '0;
		if (pix_valid)
			pix = pix_q[0];
		cls_have = (cls_q.size() > 0);
		cls_exp  = '0;
		if (cls_have)
			cls_exp = cls_q[0];
		vert_have = (vert_q.size() > 0);
		vert_exp  = '0;
		if (vert_have)
			vert_exp = vert_q[0];
	endfunction

	task automatic queue_pixel(input logic [23:0] p);
		busy = 1'b1;
		pix_q.push_back(p);
		cls_q.push_back(head_ref(p, CLS_BASE));
		vert_q.push_back(head_ref(p, VERT_BASE));
		show_queue_heads();
	endtask

	task automatic wait_drain();
		while (pix_q.size() > 0 || cls_q.size() > 0 || vert_q.size() > 0)
			@(negedge clk);
		repeat (4) @(negedge clk); // Catch stray results
	endtask

	task automatic check_results(input int n_cls, input int n_vert, input int want);
		a_result_count: assert (n_cls == want && n_vert == want)
		else begin
			other_errs++;
			$display("Wrong result count: %0d cls and %0d vert, %0d wanted", n_cls, n_vert, want);
		end
	endtask

	always @(posedge clk)
		pix_taken <= pix_rd_en;

	// Retire what the last edge consumed, then present new heads
	always @(negedge clk) begin
		if (pix_taken && pix_q.size() > 0)
			void'(pix_q.pop_front());
		if (cls_shown && cls_q.size() > 0)
			void'(cls_q.pop_front());
		if (vert_shown && vert_q.size() > 0)
			void'(vert_q.pop_front());
		cls_shown = cls_valid;
		vert_shown = vert_valid;
		cls_seen += int'(cls_valid);
		vert_seen += int'(vert_valid);
		show_queue_heads();
	end

	a_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!busy |-> !(cls_valid || vert_valid || pix_rd_en))
	else begin
		other_errs++;
		$display("Output activity before any pixel was queued");
	end

	a_cls_pending: assert property (@(posedge clk) disable iff (!arst_n) cls_valid |-> cls_have)
	else begin
		other_errs++;
		$display("A cls result arrived with no pixel pending");
	end

	a_vert_pending: assert property (@(posedge clk) disable iff (!arst_n) vert_valid |-> vert_have)
	else begin
		other_errs++;
		$display("A vert result arrived with no pixel pending");
	end

	a_cls_value: assert property (@(posedge clk) disable iff (!arst_n)
		cls_valid && cls_have |-> cls_data == cls_exp)
	else begin
		val_errs++;
		$display("error %0t: cls result %h, expected %h", $time, $sampled(cls_data),
			$sampled(cls_exp));
	end

	a_vert_value: assert property (@(posedge clk) disable iff (!arst_n)
		vert_valid && vert_have |-> vert_data == vert_exp)
	else begin
		val_errs++;
		$display("error %0t: vert result %h, expected %h", $time, $sampled(vert_data),
			$sampled(vert_exp));
	end

	// One result may still be in flight when the flag rises
	a_cls_hold: assert property (@(posedge clk) disable iff (!arst_n) $past(cls_af) |-> !cls_valid)
	else begin
		other_errs++;
		$display("cls head kept emitting while its almost-full flag was held");
	end

	a_vert_hold: assert property (@(posedge clk) disable iff (!arst_n)
		$past(vert_af) |-> !vert_valid)
	else begin
		other_errs++;
		$display("vert head kept emitting while its almost-full flag was held");
	end

	initial begin
		void'($urandom(78627));
		clk        = 1'b0;
		arst_n     = 1'b0;
		wt_wr      = '0;
		cls_af     = 1'b0;
		vert_af    = 1'b0;
		pix_taken  = 1'b0;
		cls_shown  = 1'b0;
		vert_shown = 1'b0;
		busy       = 1'b0;
		cls_seen   = 0;
		vert_seen  = 0;
		val_errs   = 0;
		other_errs = 0;
		show_queue_heads();
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		repeat (10) @(negedge clk); // Idle window after reset

		fill_weights();
		load_weights();
		c0 = cls_seen;
		v0 = vert_seen;
		queue_pixel(24'($urandom));
		wait_drain();
		check_results(cls_seen - c0, vert_seen - v0, 1);

		// Encoders clamp to zero, heads saturate their scaled bias
		for (int o = 0; o < 8; o++) begin
			wmem[ENC0_BASE + 24 + o] = -16'sd20000;
			wmem[ENC1_BASE + 64 + o] = -16'sd20000;
		end
		for (int o = 0; o < 4; o++) begin
			wmem[CLS_BASE + 32 + o]  = o[0] ? 16'sd30000 : -16'sd30000;
			wmem[VERT_BASE + 32 + o] = o[0] ? -16'sd30000 : 16'sd30000;
		end
		wmem[CLS_BASE + 36][15:8]  = 8'hff;
		wmem[VERT_BASE + 36][15:8] = 8'hff;
		load_weights();
		c0 = cls_seen;
		v0 = vert_seen;
		queue_pixel(24'($urandom));
		wait_drain();
		check_results(cls_seen - c0, vert_seen - v0, 1);

		fill_weights();
		load_weights();
		c0 = cls_seen;
		v0 = vert_seen;
		for (int n = 0; n < N_STREAM; n++) begin
			@(negedge clk);
			vert_af = ($urandom_range(7) == 0);
			queue_pixel(24'($urandom));
		end
		@(negedge clk);
		vert_af = 1'b0;
		wait_drain();
		check_results(cls_seen - c0, vert_seen - v0, N_STREAM);

		@(negedge clk);
		cls_af = 1'b1;
		v0 = vert_seen;
		for (int n = 0; n < N_HOLD; n++) begin
			@(negedge clk);
			queue_pixel(24'($urandom));
		end
		repeat (60) @(negedge clk);
		a_vert_runs: assert (vert_seen > v0 && cls_q.size() > 0)
		else begin
			other_errs++;
			$display("vert head did not run on while cls was held, or cls did not stall");
		end
		cls_af = 1'b0;
		wait_drain();

		$display("Checks done: %0d value errors, %0d other errors", val_errs, other_errs);
		if (val_errs + other_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks done: %0d value errors, %0d other errors", val_errs, other_errs);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verif
hw/feat_pkg.sv
hw/wload_pkg.sv
hw/weight_bank.sv
hw/pw_conv_layer.sv
hw/stream_fifo.sv
hw/fork_fifo.sv
hw/cnn_top.sv
verif/tb_cnn_top.sv

// ==== Bender.yml ====
package:
  name: cnn_feat

sources:
  - hw/feat_pkg.sv
  - hw/wload_pkg.sv
  - hw/weight_bank.sv
  - hw/pw_conv_layer.sv
  - hw/stream_fifo.sv
  - hw/fork_fifo.sv
  - hw/cnn_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_cnn_top.sv
